// ==== compile.f ====
+incdir+.
vid_pkg.sv
vid_timing.sv
obj_scan.sv
obj_slot.sv
vid_colmix.sv
vid_top.sv
vid_sva.sv
tb_vid.sv

// ==== vid_input.txt ====
# P addr rgb : palette write, addr decimal, rgb hex 3-3-2
# S index y x mask colour : sprite entry, mask hex, the rest decimal
# X frame line pixel rgb : expected output pixel, rgb hex
# T line_total frame_total frames : pixels per line, lines per frame, frames to run
P 0 25
P 8 e0
P 9 1c
P 10 03
P 11 fc
P 12 1f
P 13 e3
P 14 92
P 15 49
S 0 2 4 a5 1
S 1 5 8 ff 2
S 2 14 0 01 3
S 3 15 4 01 4
S 4 16 8 01 5
S 5 16 12 01 6
S 6 17 20 03 7
S 7 128 0 00 0
T 48 28 3
# background and blanking
X 1 0 0 25
X 1 23 31 25
X 1 3 40 00
X 1 25 5 00
# shape of sprite 0
X 1 3 3 25
X 1 3 4 1c
X 1 3 5 25
X 1 3 6 1c
X 1 3 11 1c
X 1 3 12 25
# vertical extent of sprite 0
X 1 1 4 25
X 1 2 4 1c
X 1 9 4 1c
X 1 10 4 25
# sprite 0 over sprite 1
X 1 6 8 03
X 1 6 9 1c
X 1 6 10 03
X 1 6 11 1c
X 1 6 12 03
X 1 12 9 03
X 1 13 9 25
# five sprites on lines 17 to 21, sprite 6 dropped there
X 1 18 0 fc
X 1 18 4 1f
X 1 18 8 e3
X 1 18 12 92
X 1 18 20 25
X 1 18 21 25
X 1 22 0 25
X 1 22 20 49
X 1 22 21 49
X 1 23 22 25
X 2 18 4 1f

// ==== tb_vid.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

module tb_vid;

typedef struct packed {
    logic [7:0]    frame;
    logic [7:0]    v;
    logic [7:0]    h;
    vid_pkg::rgb_t rgb;
} pix_exp_t;

typedef struct packed {
    logic [2:0]         idx;    // Table entry
    vid_pkg::spr_attr_t attr;
} spr_wr_t;

logic           clk;
logic           rst_n;
logic           pxl_cen;
logic           cpu_we;
logic [4:0]     cpu_addr;
logic [7:0]     cpu_din;
logic           prom_we;
logic [3:0]     prog_addr;
logic [7:0]     prom_din;
vid_pkg::rgb_t  rgb;
vid_pkg::sync_t sync;

pix_exp_t    exp_q[$];
bit          seen_q[$];
logic [11:0] pal_q[$];      // Palette address over colour
spr_wr_t     spr_q[$];

int line_total  = 0;
int frame_total = 0;
int n_frames    = 0;
int err_rgb     = 0;
int err_sync    = 0;
int err_other   = 0;
int cycles      = 0;
int limit;
int pos_h       = 0;
int pos_v       = 0;
int frame       = 0;
bit locked      = 0;        // Set once the output vb is first seen rising
bit cen_q       = 0;
vid_pkg::sync_t prev_sync = '0;

vid_top uut (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .cpu_we     ( cpu_we     ),
    .cpu_addr   ( cpu_addr   ),
    .cpu_din    ( cpu_din    ),
    .prom_we    ( prom_we    ),
    .prog_addr  ( prog_addr  ),
    .prom_din   ( prom_din   ),
    .rgb        ( rgb        ),
    .sync       ( sync       )
);

bind vid_top vid_sva u_sva (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .rgb        ( rgb        ),
    .sync       ( sync       ),
    .slot_valid ( slot_valid ),
    .slot_ready ( slot_ready ),
    .slot_attr  ( slot_attr  )
);

always #50 clk = ~clk;

always @(posedge clk) begin
    #1;
    pxl_cen = ~pxl_cen;     // Pixel on every second clock
end

always @(posedge clk) begin
    cen_q  <= pxl_cen;      // Outputs move after this edge
    cycles <= cycles + 1;
end

function automatic vid_pkg::sync_t expected_sync(input int h, input int v);
    vid_pkg::sync_t s;
    s.hb = h >= `H_ACTIVE;
    s.vb = v >= `V_ACTIVE;
    s.hs = (h >= `HS_START) && (h <= `HS_END);
    s.vs = (v >= `VS_START) && (v <= `VS_END);
    return s;
endfunction

task automatic check_rgb(input vid_pkg::rgb_t exp, input vid_pkg::rgb_t act);
    if (act !== exp) begin
        err_rgb++;
        $display("Error at %0t: rgb at frame %0d line %0d pixel %0d expected %h got %h",
                 $time, frame, pos_v, pos_h, exp, act);
    end
endtask

task automatic check_sync(input vid_pkg::sync_t exp, input vid_pkg::sync_t act);
    if (act !== exp) begin
        err_sync++;
        $display("Error at %0t: sync at frame %0d line %0d pixel %0d expected %b got %b",
                 $time, frame, pos_v, pos_h, exp, act);
    end
endtask

task automatic track_pixel();
    vid_pkg::sync_t s;
    vid_pkg::sync_t es;
    s = sync;
    if (locked) begin
        pos_h++;
        if (pos_h == line_total) begin
            pos_h = 0;
            pos_v++;
        end
        if (pos_v == frame_total) begin
            pos_v = 0;
            frame++;
        end
    end
    if (s.vb && !prev_sync.vb) begin
        if (locked && !(pos_v == `V_ACTIVE && pos_h == 0)) begin
            err_other++;
            $display("Vertical blanking began at line %0d pixel %0d, not at line %0d",
                     pos_v, pos_h, `V_ACTIVE);
        end
        locked = 1;
        pos_v  = `V_ACTIVE;
        pos_h  = 0;
    end
    if (locked && s.hb && !prev_sync.hb && pos_h != `H_ACTIVE) begin
        err_other++;
        $display("Horizontal blanking began at pixel %0d of line %0d, not at pixel %0d",
                 pos_h, pos_v, `H_ACTIVE);
        pos_h = `H_ACTIVE;
    end
    if (locked) begin
        es = expected_sync(pos_h, pos_v);
        check_sync(es, s);
        if (es.hb || es.vb) check_rgb('0, rgb);
        foreach (exp_q[i]) begin
            if (exp_q[i].frame == frame && exp_q[i].v == pos_v && exp_q[i].h == pos_h) begin
                check_rgb(exp_q[i].rgb, rgb);
                seen_q[i] = 1;
            end
        end
    end
    prev_sync = s;
endtask

always @(negedge clk) begin
    if (rst_n && cen_q) track_pixel();
end

task automatic read_data(output bit ok);
    int               fd;
    int               n;
    string            tok;
    logic [8*200-1:0] rest;
    int               a, b, c, d, e;
    pix_exp_t         pe;
    spr_wr_t          sw;
    ok = 0;
    fd = $fopen("vid_input.txt", "r");
    if (fd == 0) begin
        $display("Could not open the data file vid_input.txt");
        return;
    end
    while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", tok);
        if (n != 1) break;
        if (tok == "#") begin
            n = $fgets(rest, fd);   // Comment line
        end else if (tok == "P") begin
            n = $fscanf(fd, "%d %h", a, b);
            pal_q.push_back({a[3:0], b[7:0]});
        end else if (tok == "S") begin
            n = $fscanf(fd, "%d %d %d %h %d", a, b, c, d, e);
            sw.idx       = a[2:0];
            sw.attr.y    = b[7:0];
            sw.attr.x    = c[7:0];
            sw.attr.mask = d[7:0];
            sw.attr.col  = e[2:0];
            spr_q.push_back(sw);
        end else if (tok == "X") begin
            n = $fscanf(fd, "%d %d %d %h", a, b, c, d);
            pe = {a[7:0], b[7:0], c[7:0], d[7:0]};
            exp_q.push_back(pe);
            seen_q.push_back(1'b0);
        end else if (tok == "T") begin
            n = $fscanf(fd, "%d %d %d", line_total, frame_total, n_frames);
        end else begin
            err_other++;
            $display("Unknown record %s in the data file", tok);
        end
    end
    $fclose(fd);
    ok = 1;
endtask

task automatic idle_gap();
    int n;
    n = $urandom % 4;
    repeat (n) begin
        @(posedge clk);
        #1;
    end
endtask

task automatic cpu_write(input logic [4:0] addr, input logic [7:0] data);
    idle_gap();
    cpu_we   = 1'b1;
    cpu_addr = addr;
    cpu_din  = data;
    @(posedge clk);
    #1;
    cpu_we   = 1'b0;
endtask

task automatic prom_write(input logic [3:0] addr, input logic [7:0] data);
    idle_gap();
    prom_we   = 1'b1;
    prog_addr = addr;
    prom_din  = data;
    @(posedge clk);
    #1;
    prom_we   = 1'b0;
endtask

initial begin
    bit ok;
    int seed;
    clk       = 1'b0;
    rst_n     = 1'b0;
    pxl_cen   = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_din   = '0;
    prom_we   = 1'b0;
    prog_addr = '0;
    prom_din  = '0;
    seed      = 30;
    void'($urandom(seed));
    read_data(ok);
    if (!ok) err_other++;
    limit = (n_frames + 1) * `V_TOTAL * `H_TOTAL * 2;   // One frame of margin
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    foreach (pal_q[i]) prom_write(pal_q[i][11:8], pal_q[i][7:0]);
    foreach (spr_q[i]) begin
        cpu_write({spr_q[i].idx, 2'd0}, spr_q[i].attr.y);
        cpu_write({spr_q[i].idx, 2'd1}, spr_q[i].attr.x);
        cpu_write({spr_q[i].idx, 2'd2}, spr_q[i].attr.mask);
        cpu_write({spr_q[i].idx, 2'd3}, {5'd0, spr_q[i].attr.col});
    end
    while (frame < n_frames && cycles < limit) @(posedge clk);
    if (frame < n_frames) begin
        err_other++;
        $display("Timeout after %0d clocks, frame %0d of %0d was never reached",
                 cycles, n_frames, n_frames);
    end
    foreach (exp_q[i]) begin
        if (!seen_q[i]) begin
            err_other++;
            $display("Pixel at frame %0d line %0d pixel %0d was never reached",
                     exp_q[i].frame, exp_q[i].v, exp_q[i].h);
        end
    end
    $display("Checks done, rgb errors %0d, sync errors %0d, other errors %0d",
             err_rgb, err_sync, err_other);
    if (err_rgb + err_sync + err_other == 0) begin
        $display("All tests passed");
    end else begin
        $display("Some tests failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== vid_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

module vid_sva (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire vid_pkg::rgb_t          rgb,
    input  wire vid_pkg::sync_t         sync,
    input  wire logic [`NUM_SLOTS-1:0]  slot_valid,
    input  wire logic [`NUM_SLOTS-1:0]  slot_ready,
    input  wire vid_pkg::spr_attr_t     slot_attr
);

// Sync pulses sit inside blanking
a_hs_in_hb: assert property (@(posedge clk) disable iff (!rst_n) sync.hs |-> sync.hb)
    else $error("hs is high outside horizontal blanking");

a_vs_in_vb: assert property (@(posedge clk) disable iff (!rst_n) sync.vs |-> sync.vb)
    else $error("vs is high outside vertical blanking");

a_black_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
    (sync.hb || sync.vb) |-> rgb == '0)
    else $error("rgb is not black during blanking");

for (genvar k = 0; k < `NUM_SLOTS; k++) begin : g_chk
    // Offer held with the same sprite until taken
    a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (slot_valid[k] && !slot_ready[k]) |=> (slot_valid[k] && $stable(slot_attr)))
        else $error("slot %0d offer dropped or changed before transfer", k);

    a_valid_empty: assert property (@(posedge clk) disable iff (!rst_n)
        slot_valid[k] |-> slot_ready[k])
        else $error("slot %0d offered a sprite while full", k);
end

endmodule

`default_nettype wire

// ==== vid_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

module vid_top (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       pxl_cen,
    input  wire logic       cpu_we,
    input  wire logic [4:0] cpu_addr,
    input  wire logic [7:0] cpu_din,
    input  wire logic       prom_we,
    input  wire logic [3:0] prog_addr,
    input  wire logic [7:0] prom_din,
    output vid_pkg::rgb_t   rgb,
    output vid_pkg::sync_t  sync
);

vid_pkg::beam_t                         beam;
vid_pkg::spr_attr_t                     slot_attr;
vid_pkg::slot_pix_t [`NUM_SLOTS-1:0]    slot_pix;
logic [`NUM_SLOTS-1:0]                  slot_valid;
logic [`NUM_SLOTS-1:0]                  slot_ready;

vid_timing u_timing (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .beam       ( beam       )
);

obj_scan u_scan (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .beam       ( beam       ),
    .cpu_we     ( cpu_we     ),
    .cpu_addr   ( cpu_addr   ),
    .cpu_din    ( cpu_din    ),
    .slot_valid ( slot_valid ),
    .slot_ready ( slot_ready ),
    .slot_attr  ( slot_attr  )     // Shared by every slot
);

for (genvar k = 0; k < `NUM_SLOTS; k++) begin : g_slot
    obj_slot u_slot (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .pxl_cen    ( pxl_cen       ),
        .beam       ( beam          ),
        .load_valid ( slot_valid[k] ),
        .load_ready ( slot_ready[k] ),
        .attr       ( slot_attr     ),
        .pix        ( slot_pix[k]   )
    );
end

vid_colmix u_colmix (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .pxl_cen    ( pxl_cen    ),
    .beam       ( beam       ),
    .slot_pix   ( slot_pix   ),
    .prom_we    ( prom_we    ),
    .prog_addr  ( prog_addr  ),
    .prom_din   ( prom_din   ),
    .rgb        ( rgb        ),
    .sync       ( sync       )
);

endmodule

`default_nettype wire

// ==== vid_colmix.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

module vid_colmix (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   pxl_cen,
    input  wire vid_pkg::beam_t                         beam,
    input  wire vid_pkg::slot_pix_t [`NUM_SLOTS-1:0]    slot_pix,
    input  wire logic                                   prom_we,
    input  wire logic [3:0]                             prog_addr,
    input  wire logic [7:0]                             prom_din,
    output vid_pkg::rgb_t                               rgb,
    output vid_pkg::sync_t                              sync
);

vid_pkg::rgb_t  pal [16];   // 0 is background and 8..15 are sprite colours
vid_pkg::sync_t flags_q;    // Flags lined up with slot_pix

logic [3:0] pal_idx;
logic       blank;

always_ff @(posedge clk) begin
    if (prom_we) pal[prog_addr] <= vid_pkg::rgb_t'(prom_din);
end

// Lowest opaque slot wins
always_comb begin
    pal_idx = 4'd0;
    for (int i = `NUM_SLOTS - 1; i >= 0; i--) begin
        if (slot_pix[i].opaque) begin
            pal_idx = {1'b1, slot_pix[i].col};
        end
    end
end

assign blank = flags_q.hb || flags_q.vb;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        flags_q <= '0;
        sync    <= '0;
        rgb     <= '0;
    end else if (pxl_cen) begin
        flags_q.hb <= beam.hb;
        flags_q.vb <= beam.vb;
        flags_q.hs <= beam.hs;
        flags_q.vs <= beam.vs;
        sync       <= flags_q;                  // Second delay stage
        rgb        <= blank ? '0 : pal[pal_idx];
    end
end

endmodule

`default_nettype wire

// ==== obj_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_slot (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               pxl_cen,
    input  wire vid_pkg::beam_t     beam,
    input  wire logic               load_valid,
    output logic                    load_ready,
    input  wire vid_pkg::spr_attr_t attr,
    output vid_pkg::slot_pix_t      pix
);

vid_pkg::spr_attr_t attr_q;

logic       hb_q;
logic       full;
logic [7:0] dx;
logic       opaque;

assign load_ready = !full;              // Accepts only while empty
assign dx         = beam.h - attr_q.x;  // Offset into the sprite, modulo 256
assign opaque     = full && !beam.hb && (dx < 8'd8) && attr_q.mask[dx[2:0]];

always_ff @(posedge clk) begin
    if (!rst_n) begin
        hb_q <= 1'b0;
        full <= 1'b0;
        pix  <= '0;
    end else begin
        hb_q <= beam.hb;
        if (beam.hb && !hb_q) begin
            full <= 1'b0;               // Line over so the slot is free again
        end else if (load_valid && load_ready) begin
            full <= 1'b1;
        end
        if (pxl_cen) begin
            pix.opaque <= opaque;
            pix.col    <= attr_q.col;
        end
    end
end

always_ff @(posedge clk) begin
    if (load_valid && load_ready) attr_q <= attr;
end

endmodule

`default_nettype wire

// ==== obj_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

module obj_scan (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire vid_pkg::beam_t         beam,
    input  wire logic                   cpu_we,
    input  wire logic [4:0]             cpu_addr,
    input  wire logic [7:0]             cpu_din,
    output logic [`NUM_SLOTS-1:0]       slot_valid,
    input  wire logic [`NUM_SLOTS-1:0]  slot_ready,
    output vid_pkg::spr_attr_t          slot_attr
);

localparam int IW = $clog2(`NUM_SPRITES);
localparam int SW = $clog2(`NUM_SLOTS);

vid_pkg::spr_attr_t tbl [`NUM_SPRITES];

logic          hb_q;
logic          hb_rise;
logic          scanning;
logic [IW-1:0] idx;     // Table entry under test
logic [SW-1:0] nslot;   // Next free slot
logic [7:0]    tgt;
logic [7:0]    dy;
logic          hit;
logic          xfer;
logic          can_eval;

// CPU writes one byte of an entry
always_ff @(posedge clk) begin
    if (cpu_we) begin
        case (cpu_addr[1:0])
            2'd0:    tbl[cpu_addr[4:2]].y    <= cpu_din;
            2'd1:    tbl[cpu_addr[4:2]].x    <= cpu_din;
            2'd2:    tbl[cpu_addr[4:2]].mask <= cpu_din;
            default: tbl[cpu_addr[4:2]].col  <= cpu_din[2:0];
        endcase
    end
end

assign hb_rise = beam.hb && !hb_q;
assign tgt     = (beam.v == 8'(`V_TOTAL - 1)) ? 8'd0 : beam.v + 8'd1;
assign dy      = tgt - tbl[idx].y;  // Wraps modulo 256
assign hit     = dy < 8'd8;
assign xfer    = |(slot_valid & slot_ready);

// A new entry is looked at only once the previous hit has gone out
assign can_eval = scanning && !hb_rise && (!(|slot_valid) || xfer);

always_ff @(posedge clk) begin
    if (!rst_n) begin
        hb_q       <= 1'b0;
        scanning   <= 1'b0;
        idx        <= '0;
        nslot      <= '0;
        slot_valid <= '0;
    end else begin
        hb_q <= beam.hb;
        if (hb_rise) begin
            scanning   <= 1'b1;
            idx        <= '0;
            nslot      <= '0;
            slot_valid <= '0;
        end else begin
            if (xfer) slot_valid <= '0;
            if (can_eval) begin
                if (hit) begin
                    slot_valid <= {{(`NUM_SLOTS-1){1'b0}}, 1'b1} << nslot;
                    nslot      <= nslot + 1'b1;
                end
                // Stop at table end or once the last slot is taken
                if (idx == IW'(`NUM_SPRITES - 1) || (hit && nslot == SW'(`NUM_SLOTS - 1))) begin
                    scanning <= 1'b0;
                end
                idx <= idx + 1'b1;
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (can_eval && hit) slot_attr <= tbl[idx];     // Held until the transfer
end

endmodule

`default_nettype wire

// ==== vid_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

module vid_timing (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           pxl_cen,
    output vid_pkg::beam_t      beam
);

logic [7:0] h_nxt;
logic [7:0] v_nxt;
logic       h_last;
logic       v_last;

assign h_last = beam.h == 8'(`H_TOTAL - 1);
assign v_last = beam.v == 8'(`V_TOTAL - 1);

always_comb begin
    h_nxt = h_last ? 8'd0 : beam.h + 8'd1;
    v_nxt = beam.v;
    if (h_last) begin
        v_nxt = v_last ? 8'd0 : beam.v + 8'd1;  // Line steps on h wrap
    end
end

// Flags come from the next counter values so they change with the position
always_ff @(posedge clk) begin
    if (!rst_n) begin
        beam <= '0;
    end else if (pxl_cen) begin
        beam.h  <= h_nxt;
        beam.v  <= v_nxt;
        beam.hb <= h_nxt >= 8'(`H_ACTIVE);
        beam.vb <= v_nxt >= 8'(`V_ACTIVE);
        beam.hs <= (h_nxt >= 8'(`HS_START)) && (h_nxt <= 8'(`HS_END));
        beam.vs <= (v_nxt >= 8'(`VS_START)) && (v_nxt <= 8'(`VS_END));
    end
end

endmodule

`default_nettype wire

// ==== vid_pkg.sv ====
`default_nettype none

package vid_pkg;

    // Beam position as presented by the timing generator
    typedef struct packed {
        logic [7:0] h;      // Pixel within the line
        logic [7:0] v;      // Line within the frame
        logic       hb;
        logic       vb;
        logic       hs;
        logic       vs;
    } beam_t;

    // Blanking and sync flags at the video output
    typedef struct packed {
        logic hb;
        logic vb;
        logic hs;
        logic vs;
    } sync_t;

    typedef struct packed {
        logic [7:0] y;      // Top line
        logic [7:0] x;      // Left pixel
        logic [7:0] mask;   // Bit 0 is the leftmost pixel
        logic [2:0] col;
    } spr_attr_t;

    typedef struct packed {
        logic       opaque;
        logic [2:0] col;
    } slot_pix_t;

    // 3-3-2 colour with red in the top bits
    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
    } rgb_t;

endpackage

`default_nettype wire

// ==== vid_consts.svh ====
`ifndef VID_CONSTS_SVH
`define VID_CONSTS_SVH

// Screen geometry in pixels and lines
`define H_ACTIVE    32
`define H_TOTAL     48
`define V_ACTIVE    24
`define V_TOTAL     28

// Horizontal sync window with both ends included
`define HS_START    36
`define HS_END      39

// Vertical sync window with both ends included
`define VS_START    25
`define VS_END      26

// Sprite table size and sprites per line
`define NUM_SPRITES 8
`define NUM_SLOTS   4

`endif
